//--- logic/fc_pkg.sv
// Interrupt ids, widths and APB register map shared by the fabric-controller interrupt RTL
package fc_pkg;

    // ************************************************************************
    // Interrupt source space
    // ************************************************************************
    localparam int unsigned IRQ_ID_WIDTH  = 5;
    localparam int unsigned NUM_IRQS      = 32;
    localparam int unsigned NUM_FAST_IRQS = 15;

    // Event FIFO interrupt id and the core fast line that carries it
    localparam logic [IRQ_ID_WIDTH-1:0] FIFO_IRQ_ID    = 5'd26;
    localparam logic [3:0]              FIFO_FAST_LINE = 4'd10;

    // ************************************************************************
    // Register map of the interrupt controller
    // ************************************************************************

    // Only the low address bits select a register inside the APB window
    localparam int unsigned REG_OFFSET_WIDTH = 8;

    typedef enum logic [REG_OFFSET_WIDTH-1:0] {
        // Interrupt enable per id
        REG_MASK      = 8'h00,
        // Read only
        REG_PENDING   = 8'h04,
        // Write one to set a pending bit
        REG_SET       = 8'h08,
        // Write one to clear a pending bit
        REG_CLEAR     = 8'h0C,
        // Read-only last popped event id plus FIFO status
        REG_FIFO_DATA = 8'h10,
        // Bit 0 fetch enable, bit 1 core clock enable
        REG_CTRL      = 8'h14
    } irq_reg_e;

endpackage

//--- logic/apb_if.sv
// APB bus between the subsystem top level (master) and the interrupt controller (slave)
interface apb_if #(
    parameter APB_ADDR_WIDTH = 12
);

    // Request side
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [31:0]               pwdata;

    // Response side
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;

    modport master (
        output paddr,
        output psel,
        output penable,
        output pwrite,
        output pwdata,
        input  prdata,
        input  pready,
        input  pslverr
    );

    modport slave (
        input  paddr,
        input  psel,
        input  penable,
        input  pwrite,
        input  pwdata,
        output prdata,
        output pready,
        output pslverr
    );

endinterface

//--- logic/event_fifo.sv
// Circular buffer of event ids waiting for the core to take the event FIFO interrupt
module event_fifo #(
    parameter EVENT_ID_WIDTH = 8,
    parameter FIFO_DEPTH     = 4
) (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  logic                      push_i,
    input  logic [EVENT_ID_WIDTH-1:0] data_i,
    input  logic                      pop_i,

    output logic [EVENT_ID_WIDTH-1:0] head_o,
    output logic                      empty_o,
    output logic                      full_o,
    output logic                      fulln_o
);

    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    logic [EVENT_ID_WIDTH-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]      wr_ptr_q;
    logic [PTR_WIDTH-1:0]      rd_ptr_q;
    logic [CNT_WIDTH-1:0]      count_q;

    logic do_push;
    logic do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_WIDTH'(FIFO_DEPTH));
    assign fulln_o = ~full_o;
    assign head_o  = mem_q[rd_ptr_q];

    // A push into a full FIFO is lost
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Count moves only when exactly one side is active
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

//--- logic/irq_fast_remap.sv
// Maps the selected interrupt id onto the core fast lines and maps fast-line acknowledges back to ids
module irq_fast_remap (
    input  logic                              irq_req_i,
    input  logic [fc_pkg::IRQ_ID_WIDTH-1:0]   irq_id_i,
    output logic [fc_pkg::NUM_FAST_IRQS-1:0]  irq_fast_o,

    input  logic                              core_ack_i,
    input  logic [3:0]                        core_ack_id_i,
    output logic                              ack_o,
    output logic [fc_pkg::IRQ_ID_WIDTH-1:0]   ack_id_o
);

    import fc_pkg::*;

    // Id to one-hot fast line
    always_comb begin
        irq_fast_o = '0;
        if (irq_req_i) begin
            if (irq_id_i == FIFO_IRQ_ID) begin
                // Event FIFO rides on its dedicated line
                irq_fast_o[FIFO_FAST_LINE] = 1'b1;
            end else if (irq_id_i < NUM_FAST_IRQS) begin
                irq_fast_o[irq_id_i[3:0]] = 1'b1;
            end
            // Ids without a line stay pending but silent
        end
    end

    // Fast line index back to id with line 10 owned by the FIFO
    always_comb begin
        if (core_ack_id_i == FIFO_FAST_LINE) begin
            ack_id_o = FIFO_IRQ_ID;
        end else begin
            ack_id_o = {1'b0, core_ack_id_i};
        end
    end

    assign ack_o = core_ack_i;

endmodule

//--- logic/irq_cntrl.sv
// APB interrupt controller with pending and mask state, id selection, FIFO pop and core enables
module irq_cntrl #(
    parameter EVENT_ID_WIDTH = 8,
    parameter FIFO_DEPTH     = 4,
    parameter APB_ADDR_WIDTH = 12
) (
    input  logic                          clk_i,
    input  logic                          reset_i,

    apb_if.slave                          apb,

    input  logic [31:0]                   events_i,

    // Event FIFO side
    input  logic                          fifo_empty_i,
    input  logic                          fifo_full_i,
    input  logic [EVENT_ID_WIDTH-1:0]     fifo_head_i,
    output logic                          fifo_pop_o,

    // Request towards the fast line remap
    output logic                          irq_req_o,
    output logic [fc_pkg::IRQ_ID_WIDTH-1:0] irq_id_o,
    input  logic                          irq_ack_i,
    input  logic [fc_pkg::IRQ_ID_WIDTH-1:0] irq_ack_id_i,

    output logic                          fetch_en_o,
    output logic                          clock_en_o
);

    import fc_pkg::*;

    // Capacity field reported in REG_FIFO_DATA
    localparam logic [7:0] FIFO_DEPTH_FIELD = 8'(FIFO_DEPTH);

    logic [NUM_IRQS-1:0]       mask_q;
    logic [NUM_IRQS-1:0]       pending_q;
    logic [NUM_IRQS-1:0]       pending_d;
    logic [EVENT_ID_WIDTH-1:0] fifo_data_q;
    logic                      fetch_en_q;
    logic                      clock_en_q;

    logic [NUM_IRQS-1:0] fifo_irq;
    logic [NUM_IRQS-1:0] pending_all;
    logic [NUM_IRQS-1:0] irq_active;
    logic [NUM_IRQS-1:0] set_vec;
    logic [NUM_IRQS-1:0] clr_vec;
    logic [NUM_IRQS-1:0] ack_clr;

    irq_reg_e        reg_offset;
    logic            offset_valid;
    logic            apb_access;
    logic            apb_write;
    logic [15:0]     fifo_data_ext;

    // ************************************************************************
    // APB decode
    // ************************************************************************
    assign reg_offset = irq_reg_e'(apb.paddr[REG_OFFSET_WIDTH-1:0]);
    assign apb_access = apb.psel & apb.penable;
    assign apb_write  = apb_access & apb.pwrite;

    always_comb begin
        case (reg_offset)
            REG_MASK, REG_PENDING, REG_SET,
            REG_CLEAR, REG_FIFO_DATA, REG_CTRL: offset_valid = 1'b1;
            default:                            offset_valid = 1'b0;
        endcase
    end

    // No wait states
    assign apb.pready  = 1'b1;
    assign apb.pslverr = apb_access & ~offset_valid;

    always_comb begin
        fifo_data_ext                     = '0;
        fifo_data_ext[EVENT_ID_WIDTH-1:0] = fifo_data_q;
    end

    // Read data is combinational in the access phase
    always_comb begin
        case (reg_offset)
            REG_MASK:      apb.prdata = mask_q;
            REG_PENDING:   apb.prdata = pending_all;
            REG_FIFO_DATA: apb.prdata = {fifo_full_i, fifo_empty_i, 6'b0,
                                         FIFO_DEPTH_FIELD, fifo_data_ext};
            REG_CTRL:      apb.prdata = {30'b0, clock_en_q, fetch_en_q};
            default:       apb.prdata = '0;
        endcase
    end

    // ************************************************************************
    // Pending state
    // ************************************************************************

    // A non-empty FIFO keeps its id pending on top of the stored bits
    always_comb begin
        fifo_irq              = '0;
        fifo_irq[FIFO_IRQ_ID] = ~fifo_empty_i;
    end

    assign pending_all = pending_q | fifo_irq;

    always_comb begin
        ack_clr = '0;
        if (irq_ack_i) begin
            ack_clr[irq_ack_id_i] = 1'b1;
        end
    end

    assign set_vec = events_i | ((apb_write && reg_offset == REG_SET) ? apb.pwdata : '0);
    assign clr_vec = ack_clr | ((apb_write && reg_offset == REG_CLEAR) ? apb.pwdata : '0);

    // New events win over a clear in the same cycle
    assign pending_d = (pending_q & ~clr_vec) | set_vec;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_d;
        end
    end

    // ************************************************************************
    // Mask, control and FIFO data registers
    // ************************************************************************
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mask_q     <= '0;
            fetch_en_q <= 1'b0;
            clock_en_q <= 1'b0;
        end else if (apb_write) begin
            if (reg_offset == REG_MASK) begin
                mask_q <= apb.pwdata;
            end
            if (reg_offset == REG_CTRL) begin
                fetch_en_q <= apb.pwdata[0];
                clock_en_q <= apb.pwdata[1];
            end
        end
    end

    // Taking the FIFO interrupt consumes one entry
    assign fifo_pop_o = irq_ack_i & (irq_ack_id_i == FIFO_IRQ_ID) & ~fifo_empty_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fifo_data_q <= '0;
        end else if (fifo_pop_o) begin
            fifo_data_q <= fifo_head_i;
        end
    end

    assign fetch_en_o = fetch_en_q;
    assign clock_en_o = clock_en_q;

    // ************************************************************************
    // Highest enabled id goes to the core
    // ************************************************************************
    assign irq_active = pending_all & mask_q;
    assign irq_req_o  = |irq_active;

    always_comb begin
        irq_id_o = '0;
        // Later iterations override, so the top bit wins
        for (int i = 0; i < NUM_IRQS; i++) begin
            if (irq_active[i]) begin
                irq_id_o = IRQ_ID_WIDTH'(i);
            end
        end
    end

endmodule

//--- logic/fc_irq_subsystem.sv
// Interrupt subsystem top level that drives the fast lines, enables and reset of the external core
module fc_irq_subsystem #(
    parameter EVENT_ID_WIDTH = 8,
    parameter FIFO_DEPTH     = 4,
    parameter APB_ADDR_WIDTH = 12
) (
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic                               wdt_reset_i,
    input  logic                               fetch_en_i,

    // APB slave port
    input  logic [APB_ADDR_WIDTH-1:0]          apb_paddr_i,
    input  logic                               apb_psel_i,
    input  logic                               apb_penable_i,
    input  logic                               apb_pwrite_i,
    input  logic [31:0]                        apb_pwdata_i,
    output logic [31:0]                        apb_prdata_o,
    output logic                               apb_pready_o,
    output logic                               apb_pslverr_o,

    // Interrupt sources
    input  logic [fc_pkg::NUM_IRQS-1:0]        events_i,
    input  logic                               event_fifo_valid_i,
    input  logic [EVENT_ID_WIDTH-1:0]          event_fifo_data_i,
    output logic                               event_fifo_fulln_o,

    // Core side
    output logic [fc_pkg::NUM_FAST_IRQS-1:0]   irq_fast_o,
    input  logic                               irq_ack_i,
    input  logic [3:0]                         irq_ack_id_i,
    output logic                               fetch_en_o,
    output logic                               core_clock_en_o,
    output logic                               core_reset_o
);

    import fc_pkg::*;

    logic                      irq_req;
    logic [IRQ_ID_WIDTH-1:0]   irq_id;
    logic                      irq_ack;
    logic [IRQ_ID_WIDTH-1:0]   irq_ack_id;

    logic                      fifo_pop;
    logic                      fifo_empty;
    logic                      fifo_full;
    logic [EVENT_ID_WIDTH-1:0] fifo_head;

    logic                      ctrl_fetch_en;

    apb_if #(.APB_ADDR_WIDTH(APB_ADDR_WIDTH)) apb ();

    // ************************************************************************
    // APB master side from the plain ports
    // ************************************************************************
    assign apb.paddr     = apb_paddr_i;
    assign apb.psel      = apb_psel_i;
    assign apb.penable   = apb_penable_i;
    assign apb.pwrite    = apb_pwrite_i;
    assign apb.pwdata    = apb_pwdata_i;
    assign apb_prdata_o  = apb.prdata;
    assign apb_pready_o  = apb.pready;
    assign apb_pslverr_o = apb.pslverr;

    // ************************************************************************
    // Core gating
    // ************************************************************************

    // Watchdog resets only the core and leaves controller state intact
    assign core_reset_o = reset_i | wdt_reset_i;
    assign fetch_en_o   = ctrl_fetch_en & fetch_en_i;

    irq_cntrl #(
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH ),
        .FIFO_DEPTH     ( FIFO_DEPTH     ),
        .APB_ADDR_WIDTH ( APB_ADDR_WIDTH )
    ) i_irq_cntrl (
        .clk_i        ( clk_i           ),
        .reset_i      ( reset_i         ),
        .apb          ( apb             ),
        .events_i     ( events_i        ),
        .fifo_empty_i ( fifo_empty      ),
        .fifo_full_i  ( fifo_full       ),
        .fifo_head_i  ( fifo_head       ),
        .fifo_pop_o   ( fifo_pop        ),
        .irq_req_o    ( irq_req         ),
        .irq_id_o     ( irq_id          ),
        .irq_ack_i    ( irq_ack         ),
        .irq_ack_id_i ( irq_ack_id      ),
        .fetch_en_o   ( ctrl_fetch_en   ),
        .clock_en_o   ( core_clock_en_o )
    );

    event_fifo #(
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH ),
        .FIFO_DEPTH     ( FIFO_DEPTH     )
    ) i_event_fifo (
        .clk_i   ( clk_i              ),
        .reset_i ( reset_i            ),
        .push_i  ( event_fifo_valid_i ),
        .data_i  ( event_fifo_data_i  ),
        .pop_i   ( fifo_pop           ),
        .head_o  ( fifo_head          ),
        .empty_o ( fifo_empty         ),
        .full_o  ( fifo_full          ),
        .fulln_o ( event_fifo_fulln_o )
    );

    irq_fast_remap i_irq_fast_remap (
        .irq_req_i     ( irq_req      ),
        .irq_id_i      ( irq_id       ),
        .irq_fast_o    ( irq_fast_o   ),
        .core_ack_i    ( irq_ack_i    ),
        .core_ack_id_i ( irq_ack_id_i ),
        .ack_o         ( irq_ack      ),
        .ack_id_o      ( irq_ack_id   )
    );

endmodule

//--- tests/tb_fc_irq.sv
// Self-checking testbench for the interrupt subsystem; steps through a table built from a model
module tb_fc_irq;

    import fc_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int FIFO_DEPTH   = 4;
    localparam int MAX_STEPS    = 256;

    localparam logic [11:0] ADDR_MASK    = 12'h000;
    localparam logic [11:0] ADDR_PENDING = 12'h004;
    localparam logic [11:0] ADDR_SET     = 12'h008;
    localparam logic [11:0] ADDR_CLEAR   = 12'h00C;
    localparam logic [11:0] ADDR_FIFO    = 12'h010;
    localparam logic [11:0] ADDR_CTRL    = 12'h014;

    // Ids 0 to 14 without 10 plus the FIFO id
    localparam logic [31:0] EVENT_IDS_OK = 32'h0400_7BFF;

    typedef enum logic [2:0] {
        OP_WR, OP_RD, OP_EVT, OP_PUSH, OP_ACK, OP_WAIT, OP_FETCH, OP_WDT
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] exp_rdata;
        logic        exp_err;
        logic [14:0] exp_fast;
        logic        exp_fulln;
        logic        exp_fetch;
        logic        exp_clk_en;
    } step_t;

    logic        clk_i;
    logic        reset_i;
    logic        wdt_reset_i;
    logic        fetch_en_i;
    logic [11:0] apb_paddr_i;
    logic        apb_psel_i;
    logic        apb_penable_i;
    logic        apb_pwrite_i;
    logic [31:0] apb_pwdata_i;
    logic [31:0] apb_prdata_o;
    logic        apb_pready_o;
    logic        apb_pslverr_o;
    logic [31:0] events_i;
    logic        event_fifo_valid_i;
    logic [7:0]  event_fifo_data_i;
    logic        event_fifo_fulln_o;
    logic [14:0] irq_fast_o;
    logic        irq_ack_i;
    logic [3:0]  irq_ack_id_i;
    logic        fetch_en_o;
    logic        core_clock_en_o;
    logic        core_reset_o;

    // Step table and reference model state
    step_t       steps [MAX_STEPS];
    int          n_steps     = 0;
    logic        table_ready = 1'b0;
    int          n_checks    = 0;
    int          n_errors    = 0;
    logic [31:0] lcg_state   = 32'd38;
    logic [31:0] m_mask      = '0;
    logic [31:0] m_pend      = '0;
    logic [7:0]  m_fifo [$];
    logic [7:0]  m_fifo_data = '0;
    logic [1:0]  m_ctrl      = '0;
    logic        m_fetch_in  = 1'b1;

    fc_irq_subsystem #(
        .EVENT_ID_WIDTH ( 8          ),
        .FIFO_DEPTH     ( FIFO_DEPTH ),
        .APB_ADDR_WIDTH ( 12         )
    ) dut (
        .clk_i              ( clk_i              ),
        .reset_i            ( reset_i            ),
        .wdt_reset_i        ( wdt_reset_i        ),
        .fetch_en_i         ( fetch_en_i         ),
        .apb_paddr_i        ( apb_paddr_i        ),
        .apb_psel_i         ( apb_psel_i         ),
        .apb_penable_i      ( apb_penable_i      ),
        .apb_pwrite_i       ( apb_pwrite_i       ),
        .apb_pwdata_i       ( apb_pwdata_i       ),
        .apb_prdata_o       ( apb_prdata_o       ),
        .apb_pready_o       ( apb_pready_o       ),
        .apb_pslverr_o      ( apb_pslverr_o      ),
        .events_i           ( events_i           ),
        .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i  ( event_fifo_data_i  ),
        .event_fifo_fulln_o ( event_fifo_fulln_o ),
        .irq_fast_o         ( irq_fast_o         ),
        .irq_ack_i          ( irq_ack_i          ),
        .irq_ack_id_i       ( irq_ack_id_i       ),
        .fetch_en_o         ( fetch_en_o         ),
        .core_clock_en_o    ( core_clock_en_o    ),
        .core_reset_o       ( core_reset_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ************************************************************************
    // Reference model
    // ************************************************************************
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] pending_view();
        return m_pend | ((m_fifo.size() != 0) ? 32'h0400_0000 : 32'h0);
    endfunction

    function automatic logic [14:0] fast_lines();
        logic [31:0] active;
        logic [14:0] lines;
        int          top;
        active = pending_view() & m_mask;
        lines  = '0;
        top    = -1;
        for (int i = 0; i < 32; i++) begin
            if (active[i]) begin
                top = i;
            end
        end
        // FIFO id rides on line 10
        // Ids 15 and up other than 26 have no line
        if (top == 26) begin
            lines[10] = 1'b1;
        end else if (top >= 0 && top < 15) begin
            lines[top] = 1'b1;
        end
        return lines;
    endfunction

    function automatic logic reg_unmapped(input logic [11:0] addr);
        case (addr[7:0])
            8'h00, 8'h04, 8'h08, 8'h0C, 8'h10, 8'h14: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] read_value(input logic [11:0] addr);
        case (addr[7:0])
            8'h00: return m_mask;
            8'h04: return pending_view();
            // Full, empty, capacity and last popped id
            8'h10: return {m_fifo.size() == FIFO_DEPTH, m_fifo.size() == 0, 6'b0,
                           8'(FIFO_DEPTH), 8'h00, m_fifo_data};
            8'h14: return {30'b0, m_ctrl};
            default: return '0;
        endcase
    endfunction

    task automatic add_step(input op_e op, input logic [11:0] addr, input logic [31:0] data);
        step_t s;
        int    ack_id;
        s.op        = op;
        s.addr      = addr;
        s.data      = data;
        s.exp_rdata = read_value(addr);
        s.exp_err   = reg_unmapped(addr);
        case (op)
            OP_WR: begin
                case (addr[7:0])
                    8'h00: m_mask = data;
                    8'h08: m_pend = m_pend | data;
                    8'h0C: m_pend = m_pend & ~data;
                    8'h14: m_ctrl = data[1:0];
                    default: ;
                endcase
            end
            OP_EVT: m_pend = m_pend | data;
            OP_PUSH: begin
                if (m_fifo.size() < FIFO_DEPTH) begin
                    m_fifo.push_back(data[7:0]);
                end
            end
            OP_ACK: begin
                ack_id = (addr[3:0] == 4'd10) ? 26 : int'(addr[3:0]);
                m_pend[ack_id] = 1'b0;
                if (ack_id == 26 && m_fifo.size() != 0) begin
                    m_fifo_data = m_fifo.pop_front();
                end
            end
            OP_FETCH: m_fetch_in = data[0];
            default: ;
        endcase
        s.exp_fast   = fast_lines();
        s.exp_fulln  = (m_fifo.size() < FIFO_DEPTH);
        s.exp_fetch  = m_ctrl[0] & m_fetch_in;
        s.exp_clk_en = m_ctrl[1];
        steps[n_steps] = s;
        n_steps++;
    endtask

    // Acknowledge whatever line the model shows until all lines are quiet
    task automatic ack_all();
        logic [14:0] lines;
        int          line;
        lines = fast_lines();
        for (int guard = 0; guard < 32 && lines != '0; guard++) begin
            line = 0;
            for (int j = 0; j < 15; j++) begin
                if (lines[j]) begin
                    line = j;
                end
            end
            add_step(OP_ACK, 12'(line), '0);
            lines = fast_lines();
        end
    endtask

    task automatic build_table();
        logic [31:0] hi;
        logic [31:0] lo;
        // Reset state
        add_step(OP_RD, ADDR_MASK, '0);
        add_step(OP_RD, ADDR_PENDING, '0);
        add_step(OP_RD, ADDR_CTRL, '0);
        add_step(OP_RD, ADDR_FIFO, '0);
        // Register access, core enables and unmapped offsets
        add_step(OP_WR, ADDR_MASK, 32'hA5A5_0F0F);
        add_step(OP_RD, ADDR_MASK, '0);
        add_step(OP_WR, ADDR_CTRL, 32'h3);
        add_step(OP_RD, ADDR_CTRL, '0);
        add_step(OP_FETCH, '0, 32'h0);
        add_step(OP_FETCH, '0, 32'h1);
        add_step(OP_WR, ADDR_CTRL, 32'h2);
        add_step(OP_RD, ADDR_CTRL, '0);
        add_step(OP_RD, 12'h018, '0);
        add_step(OP_WR, 12'h01C, 32'hFFFF_FFFF);
        add_step(OP_WR, ADDR_CTRL, 32'h1);
        // Priority with id 14 masked off
        add_step(OP_WR, ADDR_MASK, 32'h0400_3BFF);
        for (int r = 0; r < 4; r++) begin
            hi = lcg_next();
            lo = lcg_next();
            add_step(OP_EVT, '0, {hi[31:16], lo[31:16]} & EVENT_IDS_OK);
            if (r == 1) begin
                add_step(OP_WR, ADDR_SET, 32'h0000_4008);
            end
            ack_all();
            add_step(OP_RD, ADDR_PENDING, '0);
            add_step(OP_WR, ADDR_CLEAR, 32'hFFFF_FFFF);
        end
        // Event FIFO with the fifth push dropped
        add_step(OP_WR, ADDR_MASK, 32'h0400_0000);
        for (int k = 1; k <= FIFO_DEPTH + 1; k++) begin
            add_step(OP_PUSH, '0, 32'h11 * k);
        end
        add_step(OP_RD, ADDR_FIFO, '0);
        while (m_fifo.size() != 0) begin
            add_step(OP_ACK, 12'd10, '0);
            add_step(OP_RD, ADDR_FIFO, '0);
        end
        add_step(OP_WAIT, '0, '0);
        // Ids without a fast line
        add_step(OP_WR, ADDR_MASK, 32'hFFFF_FFFF);
        add_step(OP_WR, ADDR_SET, 32'hFBFF_8000);
        add_step(OP_RD, ADDR_PENDING, '0);
        // Clearing from the top makes each unmapped id the highest in turn
        for (int u = 31; u >= 15; u--) begin
            if (u != 26) begin
                add_step(OP_WR, ADDR_CLEAR, 32'h1 << u);
            end
        end
        add_step(OP_RD, ADDR_PENDING, '0);
        // Watchdog reset keeps the registers
        add_step(OP_WR, ADDR_MASK, 32'h1234_5678);
        add_step(OP_WR, ADDR_CTRL, 32'h3);
        add_step(OP_WR, ADDR_SET, 32'h0000_0010);
        add_step(OP_WDT, '0, '0);
        add_step(OP_RD, ADDR_MASK, '0);
        add_step(OP_RD, ADDR_CTRL, '0);
        add_step(OP_RD, ADDR_PENDING, '0);
    endtask

    // ************************************************************************
    // Driving and checking
    // ************************************************************************
    task automatic tick();
        @(posedge clk_i);
        #5;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        n_checks++;
        if (act_v !== exp_v) begin
            n_errors++;
            $display("FAILED time %0t signal %s expected %h actual %h",
                     $time, name, exp_v, act_v);
        end
    endtask

    task automatic apply_step(input step_t s);
        case (s.op)
            OP_WR, OP_RD: begin
                apb_paddr_i  = s.addr;
                apb_pwrite_i = (s.op == OP_WR);
                apb_pwdata_i = s.data;
                apb_psel_i   = 1'b1;
                tick();
                apb_penable_i = 1'b1;
                // Mid access phase
                #10;
                check_value("apb_pready_o", 32'h1, apb_pready_o);
                check_value("apb_pslverr_o", s.exp_err, apb_pslverr_o);
                if (s.op == OP_RD) begin
                    check_value("apb_prdata_o", s.exp_rdata, apb_prdata_o);
                end
                tick();
                apb_psel_i    = 1'b0;
                apb_penable_i = 1'b0;
                apb_pwrite_i  = 1'b0;
            end
            OP_EVT: begin
                events_i = s.data;
                tick();
                events_i = '0;
            end
            OP_PUSH: begin
                event_fifo_valid_i = 1'b1;
                event_fifo_data_i  = s.data[7:0];
                tick();
                event_fifo_valid_i = 1'b0;
            end
            OP_ACK: begin
                irq_ack_i    = 1'b1;
                irq_ack_id_i = s.addr[3:0];
                tick();
                irq_ack_i = 1'b0;
            end
            OP_FETCH: begin
                fetch_en_i = s.data[0];
                tick();
            end
            OP_WDT: begin
                wdt_reset_i = 1'b1;
                tick();
                check_value("core_reset_o", 32'h1, core_reset_o);
                wdt_reset_i = 1'b0;
                tick();
                check_value("core_reset_o", 32'h0, core_reset_o);
            end
            default: tick();
        endcase
        check_value("irq_fast_o", s.exp_fast, irq_fast_o);
        check_value("event_fifo_fulln_o", s.exp_fulln, event_fifo_fulln_o);
        check_value("fetch_en_o", s.exp_fetch, fetch_en_o);
        check_value("core_clock_en_o", s.exp_clk_en, core_clock_en_o);
    endtask

    initial begin
        reset_i            = 1'b1;
        wdt_reset_i        = 1'b0;
        fetch_en_i         = 1'b1;
        apb_paddr_i        = '0;
        apb_psel_i         = 1'b0;
        apb_penable_i      = 1'b0;
        apb_pwrite_i       = 1'b0;
        apb_pwdata_i       = '0;
        events_i           = '0;
        event_fifo_valid_i = 1'b0;
        event_fifo_data_i  = '0;
        irq_ack_i          = 1'b0;
        irq_ack_id_i       = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #5;
        check_value("core_reset_o", 32'h1, core_reset_o);
        reset_i = 1'b0;
        for (int i = 0; i < n_steps; i++) begin
            apply_step(steps[i]);
        end
        $display("Checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Every step needs at most four cycles
    initial begin
        wait (table_ready);
        #((n_steps * 4 + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the step table did not complete in %0d cycles",
                 n_steps * 4 + RESET_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- build.f
logic/fc_pkg.sv
logic/apb_if.sv
logic/event_fifo.sv
logic/irq_fast_remap.sv
logic/irq_cntrl.sv
logic/fc_irq_subsystem.sv
tests/tb_fc_irq.sv

//--- Makefile
# Verilator build and run of the fabric-controller interrupt subsystem testbench

TB_TOP  = tb_fc_irq
RTL_TOP = fc_irq_subsystem

.PHONY: all run lint clean

all: run

run:
	verilator --binary -Wno-fatal --top-module $(TB_TOP) -f build.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only -Wall --top-module $(RTL_TOP) -f build.f

clean:
	rm -rf obj_dir
